// ==== hw/dispatch_consts.svh ====
`ifndef DISPATCH_CONSTS_SVH
`define DISPATCH_CONSTS_SVH

// datapath widths
`define DATA_W   32
`define PREG_W   6

// packet shape, operand i belongs to slot i/2
`define SLOTS    2
`define OPERANDS 4

// result bus ports
`define NUM_CDB  2

// configuration register word offsets
`define REG_CTRL     3'd0
`define REG_CNT_ALU0 3'd1
`define REG_CNT_ALU1 3'd2
`define REG_CNT_MDU  3'd3
`define REG_CNT_LSU  3'd4

`endif

// ==== hw/dispatch_pkg.sv ====
package dispatch_pkg;

    // unit type carried by each slot
    typedef enum logic [1:0] {
        FU_ALU = 2'd0,
        FU_MDU = 2'd1,
        FU_LSU = 2'd2
    } fu_type_e;

    // alu steering, parity of dest tag or everything to alu0
    typedef enum logic {
        STEER_PARITY = 1'b0,
        STEER_ALU0   = 1'b1
    } steer_mode_e;

endpackage

// ==== hw/operand_select.sv ====
`timescale 1ns/1ps
`include "dispatch_consts.svh"

module operand_select (
    input  logic                                  use_imm_i,
    input  logic [`DATA_W-1:0]                    imm_i,
    input  logic                                  arf_valid_i,
    input  logic [`DATA_W-1:0]                    arf_data_i,
    input  logic [`PREG_W-1:0]                    src_preg_i,
    input  logic [`NUM_CDB-1:0]                   cdb_valid_i,
    input  logic [`NUM_CDB-1:0][`PREG_W-1:0]      cdb_preg_i,
    input  logic [`NUM_CDB-1:0][`DATA_W-1:0]      cdb_data_i,
    input  logic                                  rob_complete_i,
    input  logic [`DATA_W-1:0]                    rob_data_i,
    output logic [`DATA_W-1:0]                    data_o,
    output logic                                  data_ready_o
);

    logic                 cdb_hit;
    logic [`DATA_W-1:0]   cdb_data;

    // scan from the top so the lowest matching port wins
    always_comb begin
        cdb_hit  = 1'b0;
        cdb_data = '0;
        for (int p = `NUM_CDB - 1; p >= 0; p--) begin
            if (cdb_valid_i[p] && (cdb_preg_i[p] == src_preg_i)) begin
                cdb_hit  = 1'b1;
                cdb_data = cdb_data_i[p];
            end
        end
    end

    always_comb begin
        data_o       = '0;
        data_ready_o = 1'b1;
        if (use_imm_i) begin
            data_o = imm_i;
        end else if (arf_valid_i) begin
            data_o = arf_data_i;
        end else if (cdb_hit) begin
            data_o = cdb_data;
        end else if (rob_complete_i) begin
            data_o = rob_data_i;
        end else begin
            // still in flight, wakeup happens in the queue
            data_ready_o = 1'b0;
        end
    end

endmodule

// ==== hw/issue_steer.sv ====
`timescale 1ns/1ps
`include "dispatch_consts.svh"

module issue_steer (
    input  logic [`SLOTS-1:0]                       slot_valid_i,
    input  dispatch_pkg::fu_type_e [`SLOTS-1:0]     fu_type_i,
    input  logic [`SLOTS-1:0][`PREG_W-1:0]          dest_preg_i,
    input  dispatch_pkg::steer_mode_e               steer_mode_i,
    output logic [`SLOTS-1:0]                       alu0_sel_o,
    output logic [`SLOTS-1:0]                       alu1_sel_o,
    output logic [`SLOTS-1:0]                       mdu_sel_o,
    output logic [`SLOTS-1:0]                       lsu_sel_o
);

    logic alu0_only;

    assign alu0_only = (steer_mode_i == dispatch_pkg::STEER_ALU0);

    always_comb begin
        alu0_sel_o = '0;
        alu1_sel_o = '0;
        mdu_sel_o  = '0;
        lsu_sel_o  = '0;
        for (int s = 0; s < `SLOTS; s++) begin
            if (slot_valid_i[s]) begin
                case (fu_type_i[s])
                    dispatch_pkg::FU_ALU: begin
                        // even tag to alu0, odd tag to alu1
                        if (alu0_only || !dest_preg_i[s][0]) begin
                            alu0_sel_o[s] = 1'b1;
                        end else begin
                            alu1_sel_o[s] = 1'b1;
                        end
                    end
                    dispatch_pkg::FU_MDU: mdu_sel_o[s] = 1'b1;
                    dispatch_pkg::FU_LSU: lsu_sel_o[s] = 1'b1;
                    default: ;
                endcase
            end
        end
    end

endmodule

// ==== hw/dispatch_stage.sv ====
`timescale 1ns/1ps
`include "dispatch_consts.svh"

module dispatch_stage (
    input  logic                                    clk,
    input  logic                                    reset_i,
    input  logic                                    flush_i,
    input  logic                                    enable_i,
    input  dispatch_pkg::steer_mode_e               steer_mode_i,
    input  logic                                    in_valid_i,
    output logic                                    in_ready_o,
    input  logic [`SLOTS-1:0]                       slot_valid_i,
    input  dispatch_pkg::fu_type_e [`SLOTS-1:0]     fu_type_i,
    input  logic [`SLOTS-1:0][`PREG_W-1:0]          dest_preg_i,
    input  logic [`OPERANDS-1:0][`PREG_W-1:0]       src_preg_i,
    input  logic [`OPERANDS-1:0]                    use_imm_i,
    input  logic [`SLOTS-1:0][`DATA_W-1:0]          imm_i,
    input  logic [`OPERANDS-1:0]                    arf_valid_i,
    input  logic [`OPERANDS-1:0][`DATA_W-1:0]       arf_data_i,
    input  logic [`OPERANDS-1:0]                    rob_complete_i,
    input  logic [`OPERANDS-1:0][`DATA_W-1:0]       rob_data_i,
    input  logic [`NUM_CDB-1:0]                     cdb_valid_i,
    input  logic [`NUM_CDB-1:0][`PREG_W-1:0]        cdb_preg_i,
    input  logic [`NUM_CDB-1:0][`DATA_W-1:0]        cdb_data_i,
    output logic [`OPERANDS-1:0][`DATA_W-1:0]       payload_data_o,
    output logic [`OPERANDS-1:0]                    payload_ready_o,
    output logic [`OPERANDS-1:0][`PREG_W-1:0]       payload_src_preg_o,
    output logic [`SLOTS-1:0][`PREG_W-1:0]          payload_dest_preg_o,
    output logic                                    alu0_valid_o,
    output logic [`SLOTS-1:0]                       alu0_sel_o,
    input  logic                                    alu0_ready_i,
    output logic                                    alu1_valid_o,
    output logic [`SLOTS-1:0]                       alu1_sel_o,
    input  logic                                    alu1_ready_i,
    output logic                                    mdu_valid_o,
    output logic [`SLOTS-1:0]                       mdu_sel_o,
    input  logic                                    mdu_ready_i,
    output logic                                    lsu_valid_o,
    output logic [`SLOTS-1:0]                       lsu_sel_o,
    input  logic                                    lsu_ready_i,
    output logic [3:0]                              take_o
);

    // queue index order: lsu, mdu, alu1, alu0
    logic [3:0]                             q_valid;
    logic [3:0]                             q_ready;
    logic [3:0][`SLOTS-1:0]                 q_sel;
    logic [3:0][`SLOTS-1:0]                 new_sel;
    logic [`OPERANDS-1:0][`DATA_W-1:0]      res_data;
    logic [`OPERANDS-1:0]                   res_ready;
    logic                                   accept;

    genvar i;
    generate
        for (i = 0; i < `OPERANDS; i++) begin : g_opnd
            operand_select u_opnd (
                .use_imm_i      (use_imm_i[i]),
                .imm_i          (imm_i[i / 2]),
                .arf_valid_i    (arf_valid_i[i]),
                .arf_data_i     (arf_data_i[i]),
                .src_preg_i     (src_preg_i[i]),
                .cdb_valid_i    (cdb_valid_i),
                .cdb_preg_i     (cdb_preg_i),
                .cdb_data_i     (cdb_data_i),
                .rob_complete_i (rob_complete_i[i]),
                .rob_data_i     (rob_data_i[i]),
                .data_o         (res_data[i]),
                .data_ready_o   (res_ready[i])
            );
        end
    endgenerate

    issue_steer u_steer (
        .slot_valid_i (slot_valid_i),
        .fu_type_i    (fu_type_i),
        .dest_preg_i  (dest_preg_i),
        .steer_mode_i (steer_mode_i),
        .alu0_sel_o   (new_sel[0]),
        .alu1_sel_o   (new_sel[1]),
        .mdu_sel_o    (new_sel[2]),
        .lsu_sel_o    (new_sel[3])
    );

    assign q_ready = {lsu_ready_i, mdu_ready_i, alu1_ready_i, alu0_ready_i};
    assign take_o  = q_valid & q_ready;

    // every queue must be empty or draining this cycle
    assign in_ready_o = enable_i && !flush_i && (&(~q_valid | q_ready));
    assign accept     = in_valid_i && in_ready_o;

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            q_valid <= '0;
        end else begin
            for (int q = 0; q < 4; q++) begin
                if (accept) begin
                    q_valid[q] <= |new_sel[q];
                end else if (take_o[q]) begin
                    q_valid[q] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            q_sel               <= new_sel;
            payload_data_o      <= res_data;
            payload_ready_o     <= res_ready;
            payload_src_preg_o  <= src_preg_i;
            payload_dest_preg_o <= dest_preg_i;
        end
    end

    assign alu0_valid_o = q_valid[0];
    assign alu1_valid_o = q_valid[1];
    assign mdu_valid_o  = q_valid[2];
    assign lsu_valid_o  = q_valid[3];
    assign alu0_sel_o   = q_sel[0];
    assign alu1_sel_o   = q_sel[1];
    assign mdu_sel_o    = q_sel[2];
    assign lsu_sel_o    = q_sel[3];

endmodule

// ==== hw/dispatch_csr.sv ====
`timescale 1ns/1ps
`include "dispatch_consts.svh"

module dispatch_csr (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        wb_cyc_i,
    input  logic                        wb_stb_i,
    input  logic                        wb_we_i,
    input  logic [2:0]                  wb_adr_i,
    input  logic [`DATA_W-1:0]          wb_dat_i,
    output logic [`DATA_W-1:0]          wb_dat_o,
    output logic                        wb_ack_o,
    input  logic [3:0]                  take_i,
    output logic                        enable_o,
    output dispatch_pkg::steer_mode_e   steer_mode_o
);

    // bit 0 enable, bit 1 steering mode
    logic [1:0]                 ctrl;
    logic [3:0][`DATA_W-1:0]    cnt;
    logic [`DATA_W-1:0]         rd_data;
    logic                       req;

    // ack drops for a cycle between back-to-back strobes
    assign req = wb_cyc_i && wb_stb_i && !wb_ack_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_ack_o <= 1'b0;
            ctrl     <= 2'b01;
        end else begin
            wb_ack_o <= req;
            if (req && wb_we_i && (wb_adr_i == `REG_CTRL)) begin
                ctrl <= wb_dat_i[1:0];
            end
        end
    end

    // per-queue packet counters, wrap on overflow
    always_ff @(posedge clk) begin
        if (reset_i) begin
            cnt <= '0;
        end else begin
            for (int q = 0; q < 4; q++) begin
                if (take_i[q]) begin
                    cnt[q] <= cnt[q] + 1'b1;
                end
            end
        end
    end

    always_comb begin
        case (wb_adr_i)
            `REG_CTRL:     rd_data = {{(`DATA_W - 2){1'b0}}, ctrl};
            `REG_CNT_ALU0: rd_data = cnt[0];
            `REG_CNT_ALU1: rd_data = cnt[1];
            `REG_CNT_MDU:  rd_data = cnt[2];
            `REG_CNT_LSU:  rd_data = cnt[3];
            default:       rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (req) begin
            wb_dat_o <= rd_data;
        end
    end

    assign enable_o     = ctrl[0];
    assign steer_mode_o = dispatch_pkg::steer_mode_e'(ctrl[1]);

endmodule

// ==== hw/dispatch_top.sv ====
`timescale 1ns/1ps
`include "dispatch_consts.svh"

module dispatch_top (
    input  logic                                    clk,
    input  logic                                    reset_i,
    input  logic                                    flush_i,
    input  logic                                    in_valid_i,
    output logic                                    in_ready_o,
    input  logic [`SLOTS-1:0]                       slot_valid_i,
    input  dispatch_pkg::fu_type_e [`SLOTS-1:0]     fu_type_i,
    input  logic [`SLOTS-1:0][`PREG_W-1:0]          dest_preg_i,
    input  logic [`OPERANDS-1:0][`PREG_W-1:0]       src_preg_i,
    input  logic [`OPERANDS-1:0]                    use_imm_i,
    input  logic [`SLOTS-1:0][`DATA_W-1:0]          imm_i,
    input  logic [`OPERANDS-1:0]                    arf_valid_i,
    input  logic [`OPERANDS-1:0][`DATA_W-1:0]       arf_data_i,
    input  logic [`OPERANDS-1:0]                    rob_complete_i,
    input  logic [`OPERANDS-1:0][`DATA_W-1:0]       rob_data_i,
    input  logic [`NUM_CDB-1:0]                     cdb_valid_i,
    input  logic [`NUM_CDB-1:0][`PREG_W-1:0]        cdb_preg_i,
    input  logic [`NUM_CDB-1:0][`DATA_W-1:0]        cdb_data_i,
    output logic [`OPERANDS-1:0][`DATA_W-1:0]       payload_data_o,
    output logic [`OPERANDS-1:0]                    payload_ready_o,
    output logic [`OPERANDS-1:0][`PREG_W-1:0]       payload_src_preg_o,
    output logic [`SLOTS-1:0][`PREG_W-1:0]          payload_dest_preg_o,
    output logic                                    alu0_valid_o,
    output logic [`SLOTS-1:0]                       alu0_sel_o,
    input  logic                                    alu0_ready_i,
    output logic                                    alu1_valid_o,
    output logic [`SLOTS-1:0]                       alu1_sel_o,
    input  logic                                    alu1_ready_i,
    output logic                                    mdu_valid_o,
    output logic [`SLOTS-1:0]                       mdu_sel_o,
    input  logic                                    mdu_ready_i,
    output logic                                    lsu_valid_o,
    output logic [`SLOTS-1:0]                       lsu_sel_o,
    input  logic                                    lsu_ready_i,
    input  logic                                    wb_cyc_i,
    input  logic                                    wb_stb_i,
    input  logic                                    wb_we_i,
    input  logic [2:0]                              wb_adr_i,
    input  logic [`DATA_W-1:0]                      wb_dat_i,
    output logic [`DATA_W-1:0]                      wb_dat_o,
    output logic                                    wb_ack_o
);

    logic                       enable;
    dispatch_pkg::steer_mode_e  steer_mode;
    logic [3:0]                 take;

    dispatch_stage u_stage (
        .clk                 (clk),
        .reset_i             (reset_i),
        .flush_i             (flush_i),
        .enable_i            (enable),
        .steer_mode_i        (steer_mode),
        .in_valid_i          (in_valid_i),
        .in_ready_o          (in_ready_o),
        .slot_valid_i        (slot_valid_i),
        .fu_type_i           (fu_type_i),
        .dest_preg_i         (dest_preg_i),
        .src_preg_i          (src_preg_i),
        .use_imm_i           (use_imm_i),
        .imm_i               (imm_i),
        .arf_valid_i         (arf_valid_i),
        .arf_data_i          (arf_data_i),
        .rob_complete_i      (rob_complete_i),
        .rob_data_i          (rob_data_i),
        .cdb_valid_i         (cdb_valid_i),
        .cdb_preg_i          (cdb_preg_i),
        .cdb_data_i          (cdb_data_i),
        .payload_data_o      (payload_data_o),
        .payload_ready_o     (payload_ready_o),
        .payload_src_preg_o  (payload_src_preg_o),
        .payload_dest_preg_o (payload_dest_preg_o),
        .alu0_valid_o        (alu0_valid_o),
        .alu0_sel_o          (alu0_sel_o),
        .alu0_ready_i        (alu0_ready_i),
        .alu1_valid_o        (alu1_valid_o),
        .alu1_sel_o          (alu1_sel_o),
        .alu1_ready_i        (alu1_ready_i),
        .mdu_valid_o         (mdu_valid_o),
        .mdu_sel_o           (mdu_sel_o),
        .mdu_ready_i         (mdu_ready_i),
        .lsu_valid_o         (lsu_valid_o),
        .lsu_sel_o           (lsu_sel_o),
        .lsu_ready_i         (lsu_ready_i),
        .take_o              (take)
    );

    // config block sees each queue handshake
    dispatch_csr u_csr (
        .clk          (clk),
        .reset_i      (reset_i),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .wb_dat_o     (wb_dat_o),
        .wb_ack_o     (wb_ack_o),
        .take_i       (take),
        .enable_o     (enable),
        .steer_mode_o (steer_mode)
    );

endmodule

// ==== tb/dispatch_tb.sv ====
`timescale 1ns/1ps
`include "dispatch_consts.svh"

module dispatch_tb;

    localparam int NUM_ROWS    = 12;
    localparam int CYCLE_LIMIT = 10 * NUM_ROWS + 200;

    // operand source codes used by the table
    localparam logic [2:0] IMM  = 3'd0;
    localparam logic [2:0] ARF  = 3'd1;
    localparam logic [2:0] CDB0 = 3'd2;
    localparam logic [2:0] CDB1 = 3'd3;
    localparam logic [2:0] BOTH = 3'd4;
    localparam logic [2:0] ROB  = 3'd5;
    localparam logic [2:0] NONE = 3'd6;

    localparam dispatch_pkg::fu_type_e F_ALU = dispatch_pkg::FU_ALU;
    localparam dispatch_pkg::fu_type_e F_MDU = dispatch_pkg::FU_MDU;
    localparam dispatch_pkg::fu_type_e F_LSU = dispatch_pkg::FU_LSU;

    logic                                   clk;
    logic                                   reset_i, flush_i, in_valid_i;
    logic                                   in_ready_o;
    logic [`SLOTS-1:0]                      slot_valid_i;
    dispatch_pkg::fu_type_e [`SLOTS-1:0]    fu_type_i;
    logic [`SLOTS-1:0][`PREG_W-1:0]         dest_preg_i;
    logic [`OPERANDS-1:0][`PREG_W-1:0]      src_preg_i;
    logic [`OPERANDS-1:0]                   use_imm_i, arf_valid_i, rob_complete_i;
    logic [`SLOTS-1:0][`DATA_W-1:0]         imm_i;
    logic [`OPERANDS-1:0][`DATA_W-1:0]      arf_data_i, rob_data_i;
    logic [`NUM_CDB-1:0]                    cdb_valid_i;
    logic [`NUM_CDB-1:0][`PREG_W-1:0]       cdb_preg_i;
    logic [`NUM_CDB-1:0][`DATA_W-1:0]       cdb_data_i;
    logic [`OPERANDS-1:0][`DATA_W-1:0]      payload_data_o;
    logic [`OPERANDS-1:0]                   payload_ready_o;
    logic [`OPERANDS-1:0][`PREG_W-1:0]      payload_src_preg_o;
    logic [`SLOTS-1:0][`PREG_W-1:0]         payload_dest_preg_o;
    logic                                   alu0_valid_o, alu1_valid_o, mdu_valid_o, lsu_valid_o;
    logic [`SLOTS-1:0]                      alu0_sel_o, alu1_sel_o, mdu_sel_o, lsu_sel_o;
    logic                                   wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
    logic [2:0]                             wb_adr_i;
    logic [`DATA_W-1:0]                     wb_dat_i, wb_dat_o;
    logic [3:0]                             q_ready;

    // queue order alu0, alu1, mdu, lsu
    wire alu0_ready_i = q_ready[0];
    wire alu1_ready_i = q_ready[1];
    wire mdu_ready_i  = q_ready[2];
    wire lsu_ready_i  = q_ready[3];
    wire [3:0]             dut_valid = {lsu_valid_o, mdu_valid_o, alu1_valid_o, alu0_valid_o};
    wire [3:0][`SLOTS-1:0] dut_sel   = {lsu_sel_o, mdu_sel_o, alu1_sel_o, alu0_sel_o};

    // reference model state
    logic [3:0]                             m_valid;
    logic [3:0][`SLOTS-1:0]                 m_sel;
    logic [`OPERANDS-1:0][`DATA_W-1:0]      m_data;
    logic [`OPERANDS-1:0]                   m_ready;
    logic [`OPERANDS-1:0][`PREG_W-1:0]      m_src;
    logic [`SLOTS-1:0][`PREG_W-1:0]         m_dest;
    logic                                   m_enable;
    dispatch_pkg::steer_mode_e              m_mode;
    int                                     m_cnt[4];
    string                                  cur_test;
    int                                     cycles;

    string                                  row_name[NUM_ROWS];
    logic [1:0]                             row_vld[NUM_ROWS];
    dispatch_pkg::fu_type_e [1:0]           row_fu[NUM_ROWS];
    logic [1:0][`PREG_W-1:0]                row_dest[NUM_ROWS];
    logic [3:0][2:0]                        row_src[NUM_ROWS];
    int                                     n_rows;

    dispatch_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    end

    task automatic report_fail(input string what, input logic [127:0] exp,
                               input logic [127:0] act);
        $display("Fail %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic add_row(input string name, input logic [1:0] vld,
                           input dispatch_pkg::fu_type_e f0, input dispatch_pkg::fu_type_e f1,
                           input logic [5:0] d0, input logic [5:0] d1,
                           input logic [2:0] s0, input logic [2:0] s1,
                           input logic [2:0] s2, input logic [2:0] s3);
        row_name[n_rows]  = name;
        row_vld[n_rows]   = vld;
        row_fu[n_rows][0] = f0;
        row_fu[n_rows][1] = f1;
        row_dest[n_rows]  = {d1, d0};
        row_src[n_rows]   = {s3, s2, s1, s0};
        n_rows++;
    endtask

    // lower priority sources stay active so the order is exercised
    task automatic drive_row(input int r);
        logic [2:0] code;
        slot_valid_i = row_vld[r];
        fu_type_i    = row_fu[r];
        dest_preg_i  = row_dest[r];
        cdb_valid_i  = '0;
        cdb_preg_i   = '0;
        for (int s = 0; s < `SLOTS; s++) begin
            imm_i[s] = 32'h1000_0000 | (r << 8) | s;
        end
        for (int p = 0; p < `NUM_CDB; p++) begin
            cdb_data_i[p] = 32'h3000_0000 | (r << 8) | p;
        end
        for (int i = 0; i < `OPERANDS; i++) begin
            code              = row_src[r][i];
            src_preg_i[i]     = 6'(r * 4 + i);
            arf_data_i[i]     = 32'h2000_0000 | (r << 8) | i;
            rob_data_i[i]     = 32'h4000_0000 | (r << 8) | i;
            use_imm_i[i]      = (code == IMM);
            arf_valid_i[i]    = (code == IMM) || (code == ARF);
            rob_complete_i[i] = (code != NONE);
            if (code == CDB0 || code == BOTH) begin
                cdb_valid_i[0] = 1'b1;
                cdb_preg_i[0]  = src_preg_i[i];
            end
            if (code == CDB1 || code == BOTH) begin
                cdb_valid_i[1] = 1'b1;
                cdb_preg_i[1]  = src_preg_i[i];
            end
        end
        // spare ports also match operands resolved above the cdb
        for (int i = 0; i < `OPERANDS; i++) begin
            if (row_src[r][i] == IMM || row_src[r][i] == ARF) begin
                if (!cdb_valid_i[0]) begin
                    cdb_valid_i[0] = 1'b1;
                    cdb_preg_i[0]  = src_preg_i[i];
                end else if (!cdb_valid_i[1]) begin
                    cdb_valid_i[1] = 1'b1;
                    cdb_preg_i[1]  = src_preg_i[i];
                end
            end
        end
        in_valid_i = 1'b1;
    endtask

    function automatic logic [32:0] expect_operand(input int i);
        if (use_imm_i[i]) return {1'b1, imm_i[i / 2]};
        if (arf_valid_i[i]) return {1'b1, arf_data_i[i]};
        for (int p = 0; p < `NUM_CDB; p++) begin
            if (cdb_valid_i[p] && cdb_preg_i[p] == src_preg_i[i]) return {1'b1, cdb_data_i[p]};
        end
        if (rob_complete_i[i]) return {1'b1, rob_data_i[i]};
        return 33'd0;
    endfunction

    task automatic capture_packet();
        logic [32:0] opnd;
        m_sel = '0;
        for (int s = 0; s < `SLOTS; s++) begin
            if (slot_valid_i[s]) begin
                if (fu_type_i[s] == F_MDU) m_sel[2][s] = 1'b1;
                else if (fu_type_i[s] == F_LSU) m_sel[3][s] = 1'b1;
                else if (m_mode == dispatch_pkg::STEER_ALU0 || !dest_preg_i[s][0])
                    m_sel[0][s] = 1'b1;
                else m_sel[1][s] = 1'b1;
            end
        end
        for (int i = 0; i < `OPERANDS; i++) begin
            opnd       = expect_operand(i);
            m_ready[i] = opnd[32];
            m_data[i]  = opnd[31:0];
        end
        m_src  = src_preg_i;
        m_dest = dest_preg_i;
    endtask

    task automatic set_ready(input bit rnd);
        for (int q = 0; q < 4; q++) begin
            q_ready[q] = rnd ? (($urandom % 4) != 0) : 1'b0;
        end
    endtask

    // check at the falling edge, advance the model across the rising edge
    task automatic run_cycle(output bit acc);
        logic       exp_ready;
        logic [3:0] take;
        logic [3:0] next_valid;
        @(negedge clk);
        assert (dut_valid == m_valid) else report_fail("queue valids", m_valid, dut_valid);
        for (int q = 0; q < 4; q++) begin
            if (m_valid[q]) begin
                assert (dut_sel[q] == m_sel[q]) else report_fail("select", m_sel[q], dut_sel[q]);
            end
        end
        if (|m_valid) begin
            assert (payload_data_o == m_data) else report_fail("data", m_data, payload_data_o);
            assert (payload_ready_o == m_ready) else report_fail("ready", m_ready, payload_ready_o);
            assert (payload_src_preg_o == m_src)
                else report_fail("src", m_src, payload_src_preg_o);
            assert (payload_dest_preg_o == m_dest)
                else report_fail("dest", m_dest, payload_dest_preg_o);
        end
        exp_ready = m_enable && !flush_i && (&(~m_valid | q_ready));
        assert (in_ready_o == exp_ready) else report_fail("in_ready", exp_ready, in_ready_o);
        acc        = in_valid_i && exp_ready;
        take       = m_valid & q_ready;
        next_valid = m_valid & ~take;
        for (int q = 0; q < 4; q++) begin
            if (take[q]) m_cnt[q]++;
        end
        if (acc) begin
            capture_packet();
            for (int q = 0; q < 4; q++) begin
                next_valid[q] = |m_sel[q];
            end
        end
        if (flush_i) next_valid = '0;
        @(posedge clk);
        #1;
        m_valid = next_valid;
    endtask

    task automatic send_packet(input int r, input bit rnd);
        bit acc;
        drive_row(r);
        acc = 1'b0;
        while (!acc) begin
            set_ready(rnd);
            run_cycle(acc);
        end
        in_valid_i = 1'b0;
    endtask

    task automatic drain();
        bit acc;
        while (|m_valid) begin
            set_ready(1'b1);
            run_cycle(acc);
        end
    endtask

    task automatic run_table(input string tag);
        for (int r = 0; r < n_rows; r++) begin
            cur_test = {tag, row_name[r]};
            send_packet(r, 1'b1);
        end
        drain();
    endtask

    task automatic wb_access(input logic we, input logic [2:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdat;
        do begin
            @(negedge clk);
        end while (!wb_ack_o);
        rdat = wb_dat_o;
        @(posedge clk);
        #1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic wb_write(input logic [2:0] adr, input logic [31:0] wdat);
        logic [31:0] unused;
        wb_access(1'b1, adr, wdat, unused);
    endtask

    task automatic wb_read_check(input string name, input logic [2:0] adr,
                                 input logic [31:0] exp);
        logic [31:0] rd;
        wb_access(1'b0, adr, 32'h0, rd);
        cur_test = name;
        assert (rd == exp) else report_fail("read data", exp, rd);
    endtask

    initial begin
        bit acc;
        void'($urandom(32'h70a2));
        reset_i    = 1'b1;
        flush_i    = 1'b0;
        in_valid_i = 1'b0;
        slot_valid_i = '0;
        fu_type_i[0] = F_ALU;
        fu_type_i[1] = F_ALU;
        dest_preg_i = '0;
        src_preg_i = '0;
        use_imm_i = '0;
        imm_i = '0;
        arf_valid_i = '0;
        arf_data_i = '0;
        rob_complete_i = '0;
        rob_data_i = '0;
        cdb_valid_i = '0;
        cdb_preg_i = '0;
        cdb_data_i = '0;
        q_ready = '0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        m_valid = '0;
        m_enable = 1'b1;
        m_mode = dispatch_pkg::STEER_PARITY;
        m_cnt = '{0, 0, 0, 0};
        cycles = 0;
        n_rows = 0;

        add_row("imm_arf",    2'b11, F_ALU, F_ALU, 6'd2,  6'd5,  IMM,  ARF,  IMM,  ARF);
        add_row("cdb_ports",  2'b11, F_ALU, F_MDU, 6'd7,  6'd8,  CDB0, CDB1, ROB,  NONE);
        add_row("cdb_both",   2'b11, F_LSU, F_ALU, 6'd10, 6'd12, BOTH, ROB,  ARF,  NONE);
        add_row("rob_none",   2'b11, F_MDU, F_LSU, 6'd3,  6'd4,  ROB,  NONE, ROB,  NONE);
        add_row("slot0_only", 2'b01, F_ALU, F_MDU, 6'd9,  6'd14, ARF,  IMM,  CDB1, ROB);
        add_row("slot1_only", 2'b10, F_LSU, F_ALU, 6'd6,  6'd13, NONE, NONE, CDB0, IMM);
        add_row("empty",      2'b00, F_ALU, F_ALU, 6'd1,  6'd2,  IMM,  IMM,  IMM,  IMM);
        add_row("alu_even",   2'b11, F_ALU, F_ALU, 6'd20, 6'd22, ARF,  ARF,  ROB,  ROB);
        add_row("alu_odd",    2'b11, F_ALU, F_ALU, 6'd21, 6'd23, CDB1, IMM,  NONE, ARF);
        add_row("mdu_pair",   2'b11, F_MDU, F_MDU, 6'd30, 6'd31, ROB,  IMM,  ARF,  CDB0);
        add_row("lsu_pair",   2'b11, F_LSU, F_LSU, 6'd32, 6'd33, IMM,  NONE, BOTH, ROB);
        add_row("cdb_miss",   2'b11, F_ALU, F_LSU, 6'd40, 6'd41, NONE, CDB0, NONE, CDB1);

        repeat (10) @(posedge clk);
        #1;
        reset_i = 1'b0;
        cur_test = "reset";
        run_cycle(acc);
        assert (!wb_ack_o) else report_fail("wb_ack", 1'b0, wb_ack_o);

        run_table("parity ");
        wb_write(`REG_CTRL, 32'h3);
        m_mode = dispatch_pkg::STEER_ALU0;
        run_table("alu0 ");

        // disabled stage must refuse a waiting packet
        wb_write(`REG_CTRL, 32'h2);
        m_enable = 1'b0;
        cur_test = "enable_off";
        drive_row(0);
        repeat (5) begin
            set_ready(1'b1);
            run_cycle(acc);
        end
        in_valid_i = 1'b0;
        wb_write(`REG_CTRL, 32'h1);
        m_enable = 1'b1;
        m_mode = dispatch_pkg::STEER_PARITY;

        // held packet is dropped by flush and never counted
        cur_test = "flush";
        send_packet(1, 1'b0);
        repeat (3) run_cycle(acc);
        drive_row(2);
        flush_i = 1'b1;
        run_cycle(acc);
        flush_i = 1'b0;
        in_valid_i = 1'b0;
        run_cycle(acc);

        wb_read_check("alu0 count", `REG_CNT_ALU0, m_cnt[0]);
        wb_read_check("alu1 count", `REG_CNT_ALU1, m_cnt[1]);
        wb_read_check("mdu count", `REG_CNT_MDU, m_cnt[2]);
        wb_read_check("lsu count", `REG_CNT_LSU, m_cnt[3]);
        wb_read_check("ctrl readback", `REG_CTRL, 32'h1);
        wb_read_check("unmapped read", 3'd7, 32'h0);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== dispatch.f ====
+incdir+hw
hw/dispatch_pkg.sv
hw/operand_select.sv
hw/issue_steer.sv
hw/dispatch_stage.sv
hw/dispatch_csr.sv
hw/dispatch_top.sv
tb/dispatch_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the dispatch testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f dispatch.f --top-module dispatch_tb -o dispatch_sim

status=0
out=$(./obj_dir/dispatch_sim) || status=$?
printf '%s\n' "$out"

if [ "$status" -eq 0 ] && printf '%s\n' "$out" | grep -qx 'STATUS: PASS'; then
    exit 0
fi
echo "simulation did not report a pass"
exit 1
